/* rtl/core_pkg.sv */
`include "wb_settings.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_t;

    // Write-back source
    typedef enum logic [1:0] {
        NONE      = 2'b00,
        PC_PLUS   = 2'b01,
        RESULT    = 2'b10,
        LOAD_DATA = 2'b11
    } wb_sel_t;

    // Load/store width, funct3 of LOAD and STORE
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_width_t;

    // Execute stage to memory stage
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
    } ex_mem_t;

    // Memory stage to write-back stage
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        word_t     result;
        word_t     load_data;
        reg_addr_t rd;
    } mem_wb_t;

    // Register file write port
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    function automatic opcode_t inst_opcode(word_t inst);
        return opcode_t'(inst[6:0]);
    endfunction

    function automatic ls_width_t inst_funct3(word_t inst);
        return ls_width_t'(inst[14:12]);
    endfunction

endpackage

/* rtl/mem_stage.sv */
`include "wb_settings.svh"

module mem_stage
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    ex_valid_i,
    input  ex_mem_t ex_i,
    output logic    mem_done_o,
    output mem_wb_t mem_o
);

    localparam int NBYTES = `XLEN / 8;
    localparam int OFF_W  = $clog2(NBYTES);
    localparam int IDX_W  = $clog2(`DMEM_WORDS);

    localparam logic [NBYTES-1:0] BYTE_MASK = 1;
    localparam logic [NBYTES-1:0] HALF_MASK = 3;

    // Steps after capture: access, wb, done, then the pc write cycle ends
    localparam logic [1:0] LAST_STEP = 2'd3;

    word_t             dmem [`DMEM_WORDS];
    ex_mem_t           ex_q;
    logic              busy_q;
    logic [1:0]        step_q;
    logic              access;

    opcode_t           op;
    ls_width_t         width;
    logic [IDX_W-1:0]  word_idx;
    logic [OFF_W-1:0]  byte_off;
    logic [OFF_W-1:0]  half_off;
    logic [NBYTES-1:0] byte_en;
    word_t             wdata;
    word_t             rdata;
    word_t             byte_shift;
    word_t             half_shift;
    word_t             load_val;

    assign op       = inst_opcode(ex_q.inst);
    assign width    = inst_funct3(ex_q.inst);
    assign word_idx = ex_q.result[OFF_W +: IDX_W];
    assign byte_off = ex_q.result[OFF_W-1:0];
    // Halfword lane ignores address bit 0
    assign half_off = {byte_off[OFF_W-1], 1'b0};
    assign access   = busy_q && (step_q == 2'd0);

    // Busy window covers one instruction, strobes inside it are dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            step_q <= 2'd0;
        end else if (!busy_q) begin
            if (ex_valid_i) begin
                busy_q <= 1'b1;
                step_q <= 2'd0;
            end
        end else begin
            step_q <= step_q + 2'd1;
            if (step_q == LAST_STEP) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && ex_valid_i) begin
            ex_q <= ex_i;
        end
    end

    // Store lanes and replicated write data
    always_comb begin
        byte_en = '0;
        wdata   = ex_q.store_data;
        case (width)
            LS_B: begin
                byte_en = BYTE_MASK << byte_off;
                wdata   = {NBYTES{ex_q.store_data[7:0]}};
            end
            LS_H: begin
                byte_en = HALF_MASK << half_off;
                wdata   = {(NBYTES / 2){ex_q.store_data[15:0]}};
            end
            LS_W: byte_en = '1;
            default: byte_en = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access && op == STORE) begin
            for (int i = 0; i < NBYTES; i++) begin
                if (byte_en[i]) begin
                    dmem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Load extraction and extension
    assign rdata      = dmem[word_idx];
    assign byte_shift = rdata >> {byte_off, 3'b000};
    assign half_shift = rdata >> {half_off, 3'b000};

    always_comb begin
        case (width)
            LS_B:    load_val = {{(`XLEN - 8){byte_shift[7]}}, byte_shift[7:0]};
            LS_H:    load_val = {{(`XLEN - 16){half_shift[15]}}, half_shift[15:0]};
            LS_W:    load_val = rdata;
            LS_BU:   load_val = {{(`XLEN - 8){1'b0}}, byte_shift[7:0]};
            LS_HU:   load_val = {{(`XLEN - 16){1'b0}}, half_shift[15:0]};
            default: load_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            mem_o.pc        <= ex_q.pc;
            mem_o.inst      <= ex_q.inst;
            mem_o.result    <= ex_q.result;
            mem_o.rd        <= ex_q.rd;
            mem_o.load_data <= (op == LOAD) ? load_val : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_done_o <= 1'b0;
        end else begin
            mem_done_o <= access;
        end
    end

endmodule

/* rtl/regfile.sv */
`include "wb_settings.svh"

module regfile
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  rf_write_t wr_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    localparam int NREGS = 2 ** `REG_ADDR_W;

    word_t regs [NREGS];

    // x0 never takes a write, so it stays at its reset value of zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && (wr_i.addr != '0)) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // Combinational read ports
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

/* rtl/wb_settings.svh */
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Datapath width of the RV32I core
`define XLEN 32

// 32 architectural registers
`define REG_ADDR_W 5

// Sequential pc increment, used for the JAL/JALR link value
`define PC_STEP 4

// Data memory depth in words
`define DMEM_WORDS 256

// Value held in pc fields before the first instruction retires
`define RESET_PC 32'h8000_0000

`endif

/* rtl/wb_stage.sv */
`include "wb_settings.svh"

module wb_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      mem_done_i,
    input  mem_wb_t   mem_i,
    output rf_write_t rf_wr_o,
    output logic      wb_active_o,
    output logic      pc_wen_o,
    output word_t     retire_pc_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WB,
        ST_DONE
    } state_t;

    state_t  state_q;
    mem_wb_t wb_q;
    opcode_t op;
    wb_sel_t wb_sel;
    word_t   pc_plus;
    word_t   wb_data;

    // Sequencer: one write-back cycle, then one retire cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (mem_done_i) begin
                        state_q <= ST_WB;
                    end
                end
                ST_WB:   state_q <= ST_DONE;
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Retire pc reads RESET_PC until something retires
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_q <= '{pc: `RESET_PC, default: '0};
        end else if (state_q == ST_IDLE && mem_done_i) begin
            wb_q <= mem_i;
        end
    end

    assign op = inst_opcode(wb_q.inst);

    // Write-back source by opcode
    always_comb begin
        case (op)
            LUI, AUIPC, OP, OP_IMM: wb_sel = RESULT;
            LOAD:                   wb_sel = LOAD_DATA;
            JAL, JALR:              wb_sel = PC_PLUS;
            default:                wb_sel = NONE;
        endcase
    end

    assign pc_plus = wb_q.pc + word_t'(`PC_STEP);

    always_comb begin
        case (wb_sel)
            PC_PLUS:   wb_data = pc_plus;
            RESULT:    wb_data = wb_q.result;
            LOAD_DATA: wb_data = wb_q.load_data;
            default:   wb_data = '0;
        endcase
    end

    assign wb_active_o = (state_q == ST_WB);
    assign pc_wen_o    = (state_q == ST_DONE);
    assign retire_pc_o = wb_q.pc;

    // Every opcode with a source writes rd, but only in the write-back cycle
    assign rf_wr_o.we   = wb_active_o && (wb_sel != NONE);
    assign rf_wr_o.addr = wb_q.rd;
    assign rf_wr_o.data = wb_data;

endmodule

/* rtl/wb_top.sv */
`include "wb_settings.svh"

module wb_top
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ex_valid_i,
    input  ex_mem_t   ex_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    output logic      wb_active_o,
    output logic      pc_wen_o,
    output word_t     retire_pc_o
);

    logic      mem_done;
    mem_wb_t   mem_wb;
    rf_write_t rf_wr;

    // Load/store on the data memory
    mem_stage mem_stage_i (
        .clk        (clk),
        .rst        (rst),
        .ex_valid_i (ex_valid_i),
        .ex_i       (ex_i),
        .mem_done_o (mem_done),
        .mem_o      (mem_wb)
    );

    // Result select and retire
    wb_stage wb_stage_i (
        .clk         (clk),
        .rst         (rst),
        .mem_done_i  (mem_done),
        .mem_i       (mem_wb),
        .rf_wr_o     (rf_wr),
        .wb_active_o (wb_active_o),
        .pc_wen_o    (pc_wen_o),
        .retire_pc_o (retire_pc_o)
    );

    regfile regfile_i (
        .clk        (clk),
        .rst        (rst),
        .wr_i       (rf_wr),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module wb_tb -o wb_sim

# Output goes to the terminal, the exit status comes from the search
./obj_dir/wb_sim | tee /dev/stderr | grep -x "No errors" > /dev/null

/* src.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/regfile.sv
rtl/wb_top.sv
test/wb_assertions.sv
test/wb_tb.sv

/* test/wb_assertions.sv */
module wb_assertions (
    input logic clk,
    input logic rst,
    input logic ex_valid_i,
    input logic mem_done_i,
    input logic rf_we_i,
    input logic wb_active_i,
    input logic pc_wen_i
);

    // Retire strobe four edges after an accepted instruction
    retire_latency: assert property (@(posedge clk) disable iff (rst)
        ex_valid_i |-> ##4 pc_wen_i)
        else $error("pc_wen_o did not follow ex_valid_i by four cycles");

    // Upstream keeps quiet until the retire cycle has ended
    no_issue_while_busy: assert property (@(posedge clk) disable iff (rst)
        ex_valid_i |=> !ex_valid_i [*4])
        else $error("ex_valid_i raised inside the busy window");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !(pc_wen_i || wb_active_i || mem_done_i || rf_we_i))
        else $error("strobe high right after reset");

    // Register write only in the write-back cycle right after the memory stage is done
    rf_write_in_wb: assert property (@(posedge clk) disable iff (rst)
        rf_we_i |-> wb_active_i && $past(mem_done_i))
        else $error("register write outside the write-back cycle");

endmodule

bind wb_top wb_assertions wb_assertions_i (
    .clk         (clk),
    .rst         (rst),
    .ex_valid_i  (ex_valid_i),
    .mem_done_i  (mem_done),
    .rf_we_i     (rf_wr.we),
    .wb_active_i (wb_active_o),
    .pc_wen_i    (pc_wen_o)
);

/* test/wb_tb.sv */
`include "wb_settings.svh"

module wb_tb
    import core_pkg::*;
();

    localparam int MEM_BYTES = 4 * `DMEM_WORDS;
    localparam int BA_W = $clog2(MEM_BYTES);
    localparam word_t MEM_BASE = 32'h0000_0200;
    localparam int MEM_SPAN = 64;
    localparam int RANDOM_INSTRS = 200;
    localparam logic [6:0] UNDEF_OP = 7'b0001011;
    // About 300 instructions at 5 cycles each plus register reads, 4x margin
    localparam int PLANNED_INSTRS = 300;
    localparam int CYCLES_PER_INSTR = 5;
    localparam int TIMEOUT_CYCLES = 4 * PLANNED_INSTRS * CYCLES_PER_INSTR;

    logic      clk;
    logic      rst;
    logic      ex_valid;
    ex_mem_t   ex;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wb_active;
    logic      pc_wen;
    word_t     retire_pc;

    word_t       ref_regs [32];
    logic [7:0]  ref_mem [MEM_BYTES];
    word_t       next_pc;
    int          err_count;
    int          check_count;
    int          cycle_count;

    wb_top wb_top_i (
        .clk         (clk),
        .rst         (rst),
        .ex_valid_i  (ex_valid),
        .ex_i        (ex),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .wb_active_o (wb_active),
        .pc_wen_o    (pc_wen),
        .retire_pc_o (retire_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // Little-endian byte model, addresses wrap at the memory size
    function automatic word_t model_load(word_t addr, logic [2:0] f3);
        logic [BA_W-1:0] b;
        logic [BA_W-1:0] h;
        logic [BA_W-1:0] w;
        logic [15:0]     half;
        b = addr[BA_W-1:0];
        h = {b[BA_W-1:1], 1'b0};
        w = {b[BA_W-1:2], 2'b00};
        half = {ref_mem[{h[BA_W-1:1], 1'b1}], ref_mem[h]};
        case (f3)
            3'b000: return {{24{ref_mem[b][7]}}, ref_mem[b]};
            3'b001: return {{16{half[15]}}, half};
            3'b010: return {ref_mem[{w[BA_W-1:2], 2'd3}], ref_mem[{w[BA_W-1:2], 2'd2}],
                            ref_mem[{w[BA_W-1:2], 2'd1}], ref_mem[w]};
            3'b100: return {24'd0, ref_mem[b]};
            3'b101: return {16'd0, half};
            default: return '0;
        endcase
    endfunction

    function automatic void model_store(word_t addr, logic [2:0] f3, word_t data);
        logic [BA_W-1:0] b;
        b = addr[BA_W-1:0];
        case (f3)
            3'b000: ref_mem[b] = data[7:0];
            3'b001: begin
                ref_mem[{b[BA_W-1:1], 1'b0}] = data[7:0];
                ref_mem[{b[BA_W-1:1], 1'b1}] = data[15:8];
            end
            3'b010: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[{b[BA_W-1:2], 2'(i)}] = data[8*i +: 8];
                end
            end
            default: ;
        endcase
    endfunction

    function automatic void model_retire(word_t pc, word_t inst, word_t result,
                                         word_t sdata, reg_addr_t rd);
        logic  wr;
        word_t val;
        wr  = 1'b1;
        val = result;
        case (inst[6:0])
            LUI, AUIPC, OP, OP_IMM: val = result;
            JAL, JALR:              val = pc + `PC_STEP;
            LOAD:                   val = model_load(result, inst[14:12]);
            STORE: begin
                model_store(result, inst[14:12], sdata);
                wr = 1'b0;
            end
            default:                wr = 1'b0;
        endcase
        if (wr && rd != '0) begin
            ref_regs[rd] = val;
        end
    endfunction

    function automatic word_t make_inst(logic [6:0] opc, logic [2:0] f3, reg_addr_t rd);
        word_t inst;
        inst = $urandom;
        inst[6:0] = opc;
        inst[11:7] = rd;
        inst[14:12] = f3;
        return inst;
    endfunction

    function automatic logic [6:0] pick_opcode(int k);
        case (k)
            0: return LUI;
            1: return AUIPC;
            2: return JAL;
            3: return JALR;
            4: return BRANCH;
            5: return LOAD;
            6: return STORE;
            7: return OP_IMM;
            8: return OP;
            9: return SYSTEM;
            default: return UNDEF_OP;
        endcase
    endfunction

    // Valid load widths, the first three also serve as store widths
    function automatic logic [2:0] width_code(int k);
        case (k)
            0: return 3'b000;
            1: return 3'b001;
            2: return 3'b010;
            3: return 3'b100;
            default: return 3'b101;
        endcase
    endfunction

    // One instruction from upstream, then wait for its retire strobe
    task automatic issue(input word_t inst, input word_t result, input word_t sdata,
                         input reg_addr_t rd);
        int    waited;
        logic  seen_active;
        word_t pc;
        pc = next_pc;
        next_pc = next_pc + `PC_STEP;
        @(negedge clk);
        ex_valid = 1'b1;
        ex = '{pc: pc, inst: inst, result: result, store_data: sdata, rd: rd};
        @(negedge clk);
        ex_valid = 1'b0;
        ex = '0;
        waited = 0;
        seen_active = 1'b0;
        while (!pc_wen && waited < 8) begin
            seen_active = seen_active | wb_active;
            @(negedge clk);
            waited++;
        end
        if (!pc_wen) begin
            err_count++;
            $display("No pc_wen_o pulse for the instruction at pc %h", pc);
        end else begin
            check_word("retire_pc_o", retire_pc, pc);
            check_flag("wb_active_o seen", seen_active, 1'b1);
        end
        model_retire(pc, inst, result, sdata, rd);
    endtask

    task automatic check_reg(input reg_addr_t rd);
        @(negedge clk);
        rs1_addr = rd;
        #1;
        check_word($sformatf("x%0d", rd), rs1_data, ref_regs[rd]);
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < 32; i += 2) begin
            @(negedge clk);
            rs1_addr = reg_addr_t'(i);
            rs2_addr = reg_addr_t'(i + 1);
            #1;
            check_word($sformatf("x%0d", i), rs1_data, ref_regs[i]);
            check_word($sformatf("x%0d", i + 1), rs2_data, ref_regs[i + 1]);
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (err_count == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, err_count - errs_at_start);
        end
    endtask

    task automatic test_reset();
        int errs_at_start;
        errs_at_start = err_count;
        check_flag("wb_active_o", wb_active, 1'b0);
        check_flag("pc_wen_o", pc_wen, 1'b0);
        check_all_regs();
        finish_test("reset", errs_at_start);
    endtask

    task automatic test_alu_writes();
        int errs_at_start;
        errs_at_start = err_count;
        issue(make_inst(LUI, 3'($urandom), 5'd1), 32'h1234_5000, $urandom, 5'd1);
        issue(make_inst(AUIPC, 3'($urandom), 5'd2), 32'h8000_1010, $urandom, 5'd2);
        issue(make_inst(OP, 3'b000, 5'd3), 32'hDEAD_BEEF, $urandom, 5'd3);
        issue(make_inst(OP_IMM, 3'b110, 5'd31), 32'hFFFF_FFFF, $urandom, 5'd31);
        issue(make_inst(OP, 3'b100, 5'd0), 32'h5555_AAAA, $urandom, 5'd0);
        issue(make_inst(LUI, 3'($urandom), 5'd0), 32'hABCD_E000, $urandom, 5'd0);
        issue(make_inst(LUI, 3'($urandom), 5'd1), 32'h0F0F_0000, $urandom, 5'd1);
        check_all_regs();
        finish_test("alu_writes", errs_at_start);
    endtask

    task automatic test_jumps();
        int errs_at_start;
        errs_at_start = err_count;
        issue(make_inst(JAL, 3'($urandom), 5'd5), $urandom, $urandom, 5'd5);
        issue(make_inst(JALR, 3'b000, 5'd6), $urandom, $urandom, 5'd6);
        issue(make_inst(JAL, 3'($urandom), 5'd0), $urandom, $urandom, 5'd0);
        check_all_regs();
        finish_test("jumps", errs_at_start);
    endtask

    task automatic test_load_store();
        int    errs_at_start;
        word_t addr;
        reg_addr_t rd;
        errs_at_start = err_count;
        // Fill the test region first
        for (int i = 0; i < MEM_SPAN / 4; i++) begin
            addr = MEM_BASE + 4 * i;
            issue(make_inst(STORE, 3'b010, 5'd7), addr,
                  addr * 32'h9E37_79B9 + 32'h0F1E_2D3C, 5'd7);
        end
        issue(make_inst(STORE, 3'b000, 5'd7), MEM_BASE + 32'h01, 32'h1234_56A5, 5'd7);
        issue(make_inst(STORE, 3'b000, 5'd8), MEM_BASE + 32'h06, 32'h0000_0080, 5'd8);
        issue(make_inst(STORE, 3'b001, 5'd9), MEM_BASE + 32'h08, 32'hFFFF_8001, 5'd9);
        issue(make_inst(STORE, 3'b001, 5'd9), MEM_BASE + 32'h0B, 32'h0000_7FF0, 5'd9);
        issue(make_inst(STORE, 3'b001, 5'd4), MEM_BASE + 32'h0E, 32'h0000_C3C3, 5'd4);
        issue(make_inst(STORE, 3'b010, 5'd4), MEM_BASE + 32'h10, 32'h89AB_CDEF, 5'd4);
        issue(make_inst(STORE, 3'b010, 5'd3), MEM_BASE + 32'h15, 32'hF00D_CAFE, 5'd3);
        // Stores leave every register alone
        check_all_regs();
        for (int off = 0; off < 12; off++) begin
            for (int k = 0; k < 5; k++) begin
                rd = reg_addr_t'(10 + k);
                issue(make_inst(LOAD, width_code(k), rd), MEM_BASE + off, $urandom, rd);
                check_reg(rd);
            end
        end
        finish_test("load_store", errs_at_start);
    endtask

    task automatic test_no_writes();
        int errs_at_start;
        errs_at_start = err_count;
        issue(make_inst(BRANCH, 3'b001, 5'd12), $urandom, $urandom, 5'd12);
        issue(make_inst(SYSTEM, 3'b000, 5'd13), $urandom, $urandom, 5'd13);
        issue(make_inst(UNDEF_OP, 3'b000, 5'd14), $urandom, $urandom, 5'd14);
        check_all_regs();
        finish_test("no_writes", errs_at_start);
    endtask

    task automatic test_random();
        int         errs_at_start;
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      result;
        reg_addr_t  rd;
        errs_at_start = err_count;
        for (int n = 0; n < RANDOM_INSTRS; n++) begin
            opc = pick_opcode($urandom_range(0, 10));
            f3 = 3'($urandom);
            result = $urandom;
            rd = reg_addr_t'($urandom_range(0, 31));
            // Memory ops stay inside the filled region
            if (opc == LOAD) begin
                f3 = width_code($urandom_range(0, 4));
                result = MEM_BASE + $urandom_range(0, MEM_SPAN - 1);
            end else if (opc == STORE) begin
                f3 = width_code($urandom_range(0, 2));
                result = MEM_BASE + $urandom_range(0, MEM_SPAN - 1);
            end
            issue(make_inst(opc, f3, rd), result, $urandom, rd);
        end
        check_all_regs();
        finish_test("random", errs_at_start);
    endtask

    initial begin
        void'($urandom(33896));
        rst = 1'b1;
        ex_valid = 1'b0;
        ex = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        err_count = 0;
        check_count = 0;
        cycle_count = 0;
        next_pc = `RESET_PC;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_alu_writes();
        test_jumps();
        test_load_store();
        test_no_writes();
        test_random();
        $display("Checks: %0d, mismatches: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
